//--- bench/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int HALT_TIMEOUT = 200;
    localparam int IDLE_CYCLES  = 10;
    localparam logic [31:0] JAL_ADDR = 32'hBFC00030;
    localparam logic [31:0] MARKER   = 32'd1;

    logic        clk;
    logic        rst;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    // behavioral 1 KB data memory
    logic [31:0] mem [0:255];
    logic [31:0] word0;
    logic [31:0] word1;
    integer      seed;
    bit          test_ok;
    bit          halted;
    int          pass_count;
    int          fail_count;

    mips_core u_mips_core (
        .clk            (clk),
        .rst            (rst),
        .active         (active),
        .register_v0    (register_v0),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign data_readdata = mem[data_address[9:2]];

    always @(posedge clk) begin
        if (data_write) begin
            mem[data_address[9:2]] <= data_writedata;
        end
    end

    function automatic logic [31:0] fill_word(input logic [9:0] byte_addr);
        return 32'hA5000000 | {22'd0, byte_addr};
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s expected %08h actual %08h", test, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic close_test(input string test);
        if (test_ok) begin
            $display("%s: pass", test);
            pass_count++;
        end else begin
            $display("%s: fail", test);
            fail_count++;
        end
        test_ok = 1'b1;
    endtask

    // polls on the falling edge until active drops
    task automatic wait_for_halt(output bit done);
        int cycles;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (!active) begin
                done = 1'b1;
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        seed       = 75694;
        test_ok    = 1'b1;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] <= fill_word({i[7:0], 2'b00});
        end
        word0  = $random(seed);
        word1  = $random(seed);
        mem[0] <= word0;
        mem[1] <= word1;

        repeat (4) @(negedge clk);
        rst = 1'b0;

        // first instruction is lw
        check_value("reset_start", 32'd1, {31'd0, active});
        check_value("reset_start", 32'd1, {31'd0, data_read});
        close_test("reset_start");

        wait_for_halt(halted);

        check_value("load_add_store", word0 + word1, mem[32'h100 >> 2]);
        close_test("load_add_store");

        // taken branch writes slot and target but not the skipped store
        check_value("branches", MARKER, mem[32'h108 >> 2]);
        check_value("branches", fill_word(10'h10C), mem[32'h10C >> 2]);
        check_value("branches", MARKER, mem[32'h110 >> 2]);
        check_value("branches", MARKER, mem[32'h114 >> 2]);
        check_value("branches", MARKER, mem[32'h118 >> 2]);
        close_test("branches");

        check_value("jal_link", JAL_ADDR + 32'd8, mem[32'h104 >> 2]);
        close_test("jal_link");

        if (!halted) begin
            $display("halt: active did not fall within %0d cycles", HALT_TIMEOUT);
            test_ok = 1'b0;
        end else begin
            check_value("halt", MARKER, mem[32'h11C >> 2]);
            for (int n = 1; n <= IDLE_CYCLES; n++) begin
                @(negedge clk);
                assert (!data_write && !data_read) else begin
                    $display("halt: memory strobe seen %0d cycles after active fell", n);
                    test_ok = 1'b0;
                end
                check_value("halt", 32'd0, {31'd0, active});
                check_value("halt", word0, register_v0);
            end
        end
        close_test("halt");

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips_core -f sim.f -o sim_mips_core

./obj_dir/sim_mips_core | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- sim.f
verilog/mips_pkg.sv
verilog/mips_ifs.sv
verilog/instr_rom.sv
verilog/decode.sv
verilog/execute.sv
verilog/result.sv
verilog/mips_core.sv
bench/tb_mips_core.sv

//--- verilog/decode.sv
`timescale 1ns/1ps

module decode import mips_pkg::*; (
    input  logic [WORD-1:0]  instr,
    output logic [REG_W-1:0] rs_index,
    output logic [REG_W-1:0] rt_index,
    input  logic [WORD-1:0]  rs_value,
    input  logic [WORD-1:0]  rt_value,
    dec_bus.source           dec
);

    logic [REG_W-1:0] rd;
    logic [IMM_W-1:0] imm;
    funct_t           funct;

    // instruction fields
    assign rs_index = instr[25:21];
    assign rt_index = instr[20:16];
    assign rd       = instr[15:11];
    assign imm      = instr[IMM_W-1:0];
    assign funct    = funct_t'(instr[5:0]);

    assign dec.opcode     = opcode_t'(instr[31:26]);
    assign dec.funct      = funct;
    assign dec.rs_val     = rs_value;
    assign dec.rt_val     = rt_value;
    assign dec.imm_ext    = {{(WORD-IMM_W){imm[IMM_W-1]}}, imm};
    assign dec.jump_field = instr[JUMP_W-1:0];

    // destination and write-back source per opcode
    always_comb begin
        dec.dest      = rt_index;
        dec.reg_write = 1'b0;
        dec.wb_sel    = WB_ALU;
        case (dec.opcode)
            OP_SPECIAL: begin
                dec.dest      = rd;
                // jr and unknown functs write nothing
                dec.reg_write = (funct == FN_ADDU);
            end
            OP_ADDIU: begin
                dec.reg_write = 1'b1;
            end
            OP_LW: begin
                dec.reg_write = 1'b1;
                dec.wb_sel    = WB_MEM;
            end
            OP_JAL: begin
                dec.dest      = REG_LINK;
                dec.reg_write = 1'b1;
                dec.wb_sel    = WB_LINK;
            end
            default: begin
                dec.reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/execute.sv
`timescale 1ns/1ps

module execute import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    dec_bus.sink            dec,
    res_bus.source          res,
    output logic [WORD-1:0] pc,
    output logic            active,
    output logic [WORD-1:0] data_address,
    output logic [WORD-1:0] data_writedata,
    output logic            data_read,
    output logic            data_write
);

    logic [WORD-1:0] next_pc;
    halt_state_t     state;
    halt_state_t     state_next;

    logic [WORD-1:0] slot_pc;
    logic [WORD-1:0] alu_sum;
    logic [WORD-1:0] target;
    logic            taken;
    logic            is_jr;

    assign active  = (state != ST_HALTED);
    // branch targets are relative to the delay slot
    assign slot_pc = pc + 32'd4;
    assign is_jr   = (dec.opcode == OP_SPECIAL) && (dec.funct == FN_JR);

    // one adder serves addiu, addu and load/store addresses
    assign alu_sum = dec.rs_val + ((dec.opcode == OP_SPECIAL) ? dec.rt_val : dec.imm_ext);

    always_comb begin
        taken  = 1'b0;
        target = dec.rs_val;
        case (dec.opcode)
            OP_BEQ: begin
                taken  = (dec.rs_val == dec.rt_val);
                target = slot_pc + {dec.imm_ext[WORD-3:0], 2'b00};
            end
            OP_JAL: begin
                taken  = 1'b1;
                target = {slot_pc[WORD-1:WORD-4], dec.jump_field, 2'b00};
            end
            default: begin
                taken = is_jr;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_RUN: begin
                if (is_jr && dec.rs_val == '0) begin
                    state_next = ST_LAST_SLOT;
                end
            end
            ST_LAST_SLOT: state_next = ST_HALTED;
            default:      state_next = ST_HALTED;
        endcase
    end

    // pc and next_pc together hold the delay slot
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= RESET_VECTOR;
            next_pc <= RESET_VECTOR + 32'd4;
            state   <= ST_RUN;
        end else if (active) begin
            pc      <= next_pc;
            next_pc <= taken ? target : next_pc + 32'd4;
            state   <= state_next;
        end
    end

    assign data_address   = alu_sum;
    assign data_writedata = dec.rt_val;
    assign data_read      = active && (dec.opcode == OP_LW);
    assign data_write     = active && (dec.opcode == OP_SW);

    assign res.wr_en      = active && dec.reg_write;
    assign res.dest       = dec.dest;
    assign res.wb_sel     = dec.wb_sel;
    assign res.alu_value  = alu_sum;
    // return address skips the delay slot
    assign res.link_value = pc + 32'd8;

endmodule

//--- verilog/instr_rom.sv
`timescale 1ns/1ps

module instr_rom import mips_pkg::*; (
    // combinational read by byte address
    input  logic [WORD-1:0] instr_address,
    output logic [WORD-1:0] instr_readdata
);

    function automatic logic [WORD-1:0] i_type(
        opcode_t           op,
        logic [REG_W-1:0]  rs,
        logic [REG_W-1:0]  rt,
        logic [IMM_W-1:0]  imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [WORD-1:0] r_type(
        logic [REG_W-1:0]  rs,
        logic [REG_W-1:0]  rt,
        logic [REG_W-1:0]  rd,
        funct_t            fn
    );
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [WORD-1:0] j_type(opcode_t op, logic [JUMP_W-1:0] target);
        return {op, target};
    endfunction

    always_comb begin
        case (instr_address)
            // lw r2, 0(r0) and lw r3, 4(r0)
            32'hBFC00000: instr_readdata = i_type(OP_LW, 5'd0, 5'd2, 16'h0000);
            32'hBFC00004: instr_readdata = i_type(OP_LW, 5'd0, 5'd3, 16'h0004);
            // addu r4, r2, r3 then sw r4, 0x100(r0)
            32'hBFC00008: instr_readdata = r_type(5'd2, 5'd3, 5'd4, FN_ADDU);
            32'hBFC0000C: instr_readdata = i_type(OP_SW, 5'd0, 5'd4, 16'h0100);
            // r5 = 1 as the marker value
            32'hBFC00010: instr_readdata = i_type(OP_ADDIU, 5'd0, 5'd5, 16'h0001);
            // taken beq r2, r2 to BFC00020
            32'hBFC00014: instr_readdata = i_type(OP_BEQ, 5'd2, 5'd2, 16'h0002);
            // delay slot marker at 0x108
            32'hBFC00018: instr_readdata = i_type(OP_SW, 5'd0, 5'd5, 16'h0108);
            // skipped so 0x10C stays untouched
            32'hBFC0001C: instr_readdata = i_type(OP_SW, 5'd0, 5'd5, 16'h010C);
            // branch target marker at 0x110
            32'hBFC00020: instr_readdata = i_type(OP_SW, 5'd0, 5'd5, 16'h0110);
            // beq r5, r0 not taken
            32'hBFC00024: instr_readdata = i_type(OP_BEQ, 5'd5, 5'd0, 16'h0004);
            // delay slot marker 0x114 and fall-through marker 0x118
            32'hBFC00028: instr_readdata = i_type(OP_SW, 5'd0, 5'd5, 16'h0114);
            32'hBFC0002C: instr_readdata = i_type(OP_SW, 5'd0, 5'd5, 16'h0118);
            // jal B0000400 with link BFC00038
            32'hBFC00030: instr_readdata = j_type(OP_JAL, 26'h0000100);
            32'hBFC00034: instr_readdata = '0;
            // jr r0 with the final store to 0x11C in its delay slot
            32'hBFC00038: instr_readdata = r_type(5'd0, 5'd0, 5'd0, FN_JR);
            32'hBFC0003C: instr_readdata = i_type(OP_SW, 5'd0, 5'd5, 16'h011C);
            // subroutine saves r31 at 0x104 and returns
            32'hB0000400: instr_readdata = i_type(OP_SW, 5'd0, 5'd31, 16'h0104);
            32'hB0000404: instr_readdata = r_type(5'd31, 5'd0, 5'd0, FN_JR);
            32'hB0000408: instr_readdata = '0;
            // sits at the halted pc and must never take effect
            32'h00000000: instr_readdata = i_type(OP_LW, 5'd0, 5'd2, 16'h0120);
            default:      instr_readdata = '0;
        endcase
    end

endmodule

//--- verilog/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    output logic            active,
    output logic [WORD-1:0] register_v0,

    // data memory, combinational read within the cycle
    output logic [WORD-1:0] data_address,
    output logic            data_write,
    output logic            data_read,
    output logic [WORD-1:0] data_writedata,
    input  logic [WORD-1:0] data_readdata
);

    logic [WORD-1:0]  pc;
    logic [WORD-1:0]  instr;
    logic [REG_W-1:0] rs_index;
    logic [REG_W-1:0] rt_index;
    logic [WORD-1:0]  rs_value;
    logic [WORD-1:0]  rt_value;

    dec_bus u_dec_bus ();
    res_bus u_res_bus ();

    instr_rom u_instr_rom (
        .instr_address  (pc),
        .instr_readdata (instr)
    );

    decode u_decode (
        .instr    (instr),
        .rs_index (rs_index),
        .rt_index (rt_index),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .dec      (u_dec_bus.source)
    );

    execute u_execute (
        .clk            (clk),
        .rst            (rst),
        .dec            (u_dec_bus.sink),
        .res            (u_res_bus.source),
        .pc             (pc),
        .active         (active),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_read      (data_read),
        .data_write     (data_write)
    );

    result u_result (
        .clk           (clk),
        .rst           (rst),
        .res           (u_res_bus.sink),
        .data_readdata (data_readdata),
        .rs_index      (rs_index),
        .rt_index      (rt_index),
        .rs_value      (rs_value),
        .rt_value      (rt_value),
        .register_v0   (register_v0)
    );

endmodule

//--- verilog/mips_ifs.sv
`timescale 1ns/1ps

// decoded instruction, decode to execute
interface dec_bus import mips_pkg::*; ();
    opcode_t            opcode;
    funct_t             funct;
    logic [WORD-1:0]    rs_val;
    logic [WORD-1:0]    rt_val;
    logic [WORD-1:0]    imm_ext;
    logic [JUMP_W-1:0]  jump_field;
    logic [REG_W-1:0]   dest;
    logic               reg_write;
    wb_sel_t            wb_sel;

    modport source (output opcode, funct, rs_val, rt_val, imm_ext, jump_field,
                    dest, reg_write, wb_sel);
    modport sink (input opcode, funct, rs_val, rt_val, imm_ext, jump_field,
                  dest, reg_write, wb_sel);
endinterface

// write-back request, execute to result
interface res_bus import mips_pkg::*; ();
    logic               wr_en;
    logic [REG_W-1:0]   dest;
    wb_sel_t            wb_sel;
    logic [WORD-1:0]    alu_value;
    logic [WORD-1:0]    link_value;

    modport source (output wr_en, dest, wb_sel, alu_value, link_value);
    modport sink (input wr_en, dest, wb_sel, alu_value, link_value);
endinterface

//--- verilog/mips_pkg.sv
package mips_pkg;

    // datapath and field widths fixed by the instruction set
    localparam int WORD     = 32;
    localparam int REG_W    = 5;
    localparam int IMM_W    = 16;
    localparam int JUMP_W   = 26;
    localparam int NUM_REGS = 1 << REG_W;

    localparam logic [WORD-1:0]  RESET_VECTOR = 32'hBFC00000;
    localparam logic [REG_W-1:0] REG_LINK     = 5'd31;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_t;

    // function field of special instructions, bits 5:0
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001
    } funct_t;

    // run, then one more instruction after jr to zero, then stop
    typedef enum logic [1:0] {
        ST_RUN,
        ST_LAST_SLOT,
        ST_HALTED
    } halt_state_t;

    // source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_sel_t;

endpackage

//--- verilog/result.sv
`timescale 1ns/1ps

module result import mips_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    res_bus.sink             res,
    input  logic [WORD-1:0]  data_readdata,
    input  logic [REG_W-1:0] rs_index,
    input  logic [REG_W-1:0] rt_index,
    output logic [WORD-1:0]  rs_value,
    output logic [WORD-1:0]  rt_value,
    output logic [WORD-1:0]  register_v0
);

    logic [WORD-1:0] regs [NUM_REGS];
    logic [WORD-1:0] wr_value;

    // write-back mux
    always_comb begin
        case (res.wb_sel)
            WB_MEM:  wr_value = data_readdata;
            WB_LINK: wr_value = res.link_value;
            default: wr_value = res.alu_value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (res.wr_en && res.dest != '0) begin
            regs[res.dest] <= wr_value;
        end
    end

    // r0 is hardwired to zero
    assign rs_value = (rs_index == '0) ? '0 : regs[rs_index];
    assign rt_value = (rt_index == '0) ? '0 : regs[rt_index];

    // v0 for observation only
    assign register_v0 = regs[2];

endmodule
